/* hdl/float_mon_macros.svh */
// Sizing constants for the single-precision limit monitor
// Include wherever a width, the debounce length or a counter limit is needed
`ifndef FLOAT_MON_MACROS_SVH
`define FLOAT_MON_MACROS_SVH

// ==============================
// IEEE-754 single field widths
// ==============================
`define FLOAT_W      32
`define FLOAT_EXP_W  8
`define FLOAT_MAN_W  23

// ==============================
// Debounce and counters
// ==============================
// Consecutive exceeding samples before an alarm
`define DEBOUNCE_LEN 3
`define RUN_CNT_W    4
// Alarm event counter, saturates at all ones
`define EVENT_CNT_W  16

`endif

/* hdl/float_mon_pkg.sv */
// Shared types for the limit monitor
// Modules use scoped names on their ports and a wildcard import in the body
`include "float_mon_macros.svh"

package float_mon_pkg;

    // Raw single-precision word: sign, exponent, mantissa
    typedef logic [`FLOAT_W-1:0]     float32_t;

    // Consecutive exceedance run length
    typedef logic [`RUN_CNT_W-1:0]   run_cnt_t;

    // Saturating count of alarm events
    typedef logic [`EVENT_CNT_W-1:0] event_cnt_t;

    // Limit pair, held stable by the host
    typedef struct packed {
        float32_t high;
        float32_t low;
    } limit_cfg_t;

    // One-cycle record per checked sample
    typedef struct packed {
        logic valid;
        logic over;
        logic under;
    } exceed_t;

    // Live alarms and sticky history
    typedef struct packed {
        logic alarm_high;
        logic alarm_low;
        logic sticky_high;
        logic sticky_low;
    } alarm_status_t;

    // Debounce FSM, one per direction
    typedef enum logic [1:0] {
        IDLE,
        PENDING,
        ALARM
    } deb_state_t;

endpackage

/* hdl/float_gt_cmp.sv */
// Registered "a greater than b" check on two single-precision values
// Sign-magnitude ordering, one cycle of latency, no NaN or denormal handling
`timescale 1ns/10ps
`include "float_mon_macros.svh"

module float_gt_cmp (
    input  logic                    clk_sys,
    input  logic                    rst_sys_n,
    input  float_mon_pkg::float32_t a,
    input  float_mon_pkg::float32_t b,
    output logic                    a_gt_b
);

    // Field split
    logic                    sign_a;
    logic                    sign_b;
    logic [`FLOAT_EXP_W-1:0] exp_a;
    logic [`FLOAT_EXP_W-1:0] exp_b;
    logic [`FLOAT_MAN_W-1:0] man_a;
    logic [`FLOAT_MAN_W-1:0] man_b;

    // Magnitude ordering, exponent first
    logic mag_gt;
    logic mag_lt;
    logic gt_next;

    assign sign_a = a[`FLOAT_W-1];
    assign sign_b = b[`FLOAT_W-1];
    assign exp_a  = a[`FLOAT_W-2 -: `FLOAT_EXP_W];
    assign exp_b  = b[`FLOAT_W-2 -: `FLOAT_EXP_W];
    assign man_a  = a[`FLOAT_MAN_W-1:0];
    assign man_b  = b[`FLOAT_MAN_W-1:0];

    always_comb begin
        if (exp_a != exp_b) begin
            mag_gt = (exp_a > exp_b);
            mag_lt = (exp_a < exp_b);
        end else begin
            // Same exponent, mantissa decides
            mag_gt = (man_a > man_b);
            mag_lt = (man_a < man_b);
        end
    end

    always_comb begin
        if (sign_a == sign_b) begin
            // Both negative flips the sense; equal gives 0
            gt_next = sign_a ? mag_lt : mag_gt;
        end else begin
            // Positive a wins, so +0 orders above -0
            gt_next = ~sign_a;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            a_gt_b <= 1'b0;
        end else begin
            a_gt_b <= gt_next;
        end
    end

    // Result stays known once out of reset
    a_gt_b_known_a: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        !$isunknown(a_gt_b));

endmodule

/* hdl/limit_window.sv */
// Checks each valid sample against the high and low limits
// Emits one exceed record per sample, one cycle after the sample is taken
`timescale 1ns/10ps

module limit_window (
    input  logic                      clk_sys,
    input  logic                      rst_sys_n,
    input  float_mon_pkg::float32_t   sample_data,
    input  logic                      sample_valid,
    input  float_mon_pkg::limit_cfg_t limits,
    output float_mon_pkg::exceed_t    exceed
);

    // ==============================
    // Comparators
    // ==============================
    // Sample above high limit
    logic above_high;
    // Low limit above sample
    logic below_low;
    // Valid, aligned with comparator outputs
    logic valid_d;

    float_gt_cmp cmp_high_i (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .a         (sample_data),
        .b         (limits.high),
        .a_gt_b    (above_high)
    );

    // Operands swapped for the low side
    float_gt_cmp cmp_low_i (
        .clk_sys   (clk_sys),
        .rst_sys_n (rst_sys_n),
        .a         (limits.low),
        .b         (sample_data),
        .a_gt_b    (below_low)
    );

    // ==============================
    // Valid alignment
    // ==============================
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= sample_valid;
        end
    end

    // Flags gated by valid
    // Comparators still run on idle cycles, so their results are stale there
    assign exceed.valid = valid_d;
    assign exceed.over  = valid_d & above_high;
    assign exceed.under = valid_d & below_low;

    // ==============================
    // Checks
    // ==============================
    // Host keeps high >= low, so a sample cannot leave both sides
    over_under_excl_a: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        !(exceed.over && exceed.under));

    // A flag only follows a sample strobed on the previous edge
    flag_needs_sample_a: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        (exceed.over || exceed.under) |-> $past(sample_valid));

endmodule

/* hdl/alarm_debounce.sv */
// Debounces exceed records into high and low alarms
// Keeps sticky status bits cleared by status_clr and a saturating event count
// Status and count update on the edge after the exceed record
`timescale 1ns/10ps
`include "float_mon_macros.svh"

module alarm_debounce (
    input  logic                         clk_sys,
    input  logic                         rst_sys_n,
    input  float_mon_pkg::exceed_t       exceed,
    input  logic                         status_clr,
    output float_mon_pkg::alarm_status_t status,
    output float_mon_pkg::event_cnt_t    event_count
);

    import float_mon_pkg::*;

    // Bit 0 high side, bit 1 low side
    logic [1:0] hit;
    logic [1:0] rise;
    logic [1:0] alarm;
    logic [1:0] sticky;

    // Events this cycle, 0 to 2
    logic [1:0]             rise_cnt;
    logic [`EVENT_CNT_W:0]  event_sum;

    assign hit = {exceed.under, exceed.over};

    // ==============================
    // Per-direction FSM
    // ==============================
    for (genvar d = 0; d < 2; d++) begin : g_dir
        deb_state_t state;
        run_cnt_t   run_cnt;
        run_cnt_t   run_inc;
        logic       run_full;

        assign run_inc  = run_cnt + run_cnt_t'(1);
        assign run_full = (run_inc >= run_cnt_t'(`DEBOUNCE_LEN));

        // Alarm sets on the record that completes the run
        assign rise[d]  = exceed.valid && hit[d] && (state != ALARM) && run_full;
        assign alarm[d] = (state == ALARM);

        always_ff @(posedge clk_sys or negedge rst_sys_n) begin
            if (!rst_sys_n) begin
                state   <= IDLE;
                run_cnt <= '0;
            end else if (exceed.valid) begin
                if (!hit[d]) begin
                    // Any clean sample ends the run and the alarm
                    state   <= IDLE;
                    run_cnt <= '0;
                end else begin
                    case (state)
                        IDLE, PENDING: begin
                            run_cnt <= run_inc;
                            state   <= run_full ? ALARM : PENDING;
                        end
                        default: begin
                            // In alarm the run count is parked
                            state <= ALARM;
                        end
                    endcase
                end
            end
            // No record, hold everything
        end

        // Entering alarm always leaves the sticky bit set
        alarm_sets_sticky_a: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
            rise[d] |=> (state == ALARM) && sticky[d]);
    end

    // ==============================
    // Sticky bits
    // ==============================
    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            sticky <= 2'b00;
        end else begin
            // Set beats clear in the same cycle
            sticky <= rise | (sticky & ~{2{status_clr}});
        end
    end

    // ==============================
    // Event counter
    // ==============================
    assign rise_cnt  = {1'b0, rise[0]} + {1'b0, rise[1]};
    assign event_sum = {1'b0, event_count} + (`EVENT_CNT_W+1)'(rise_cnt);

    always_ff @(posedge clk_sys or negedge rst_sys_n) begin
        if (!rst_sys_n) begin
            event_count <= '0;
        end else if (event_sum[`EVENT_CNT_W]) begin
            // Carry out, pin at all ones
            event_count <= '1;
        end else begin
            event_count <= event_sum[`EVENT_CNT_W-1:0];
        end
    end

    // Count is monotonic, so it never wraps
    event_no_wrap_a: assert property (@(posedge clk_sys) disable iff (!rst_sys_n)
        event_count >= $past(event_count));

    // Status out
    assign status.alarm_high  = alarm[0];
    assign status.alarm_low   = alarm[1];
    assign status.sticky_high = sticky[0];
    assign status.sticky_low  = sticky[1];

endmodule

/* hdl/float_monitor_top.sv */
// Top level of the single-precision limit monitor
// Sample to alarm is two cycles: limit check, then debounce
`timescale 1ns/10ps

module float_monitor_top (
    input  logic                         clk_sys,
    input  logic                         rst_sys_n,
    input  float_mon_pkg::float32_t      sample_data,
    input  logic                         sample_valid,
    input  float_mon_pkg::limit_cfg_t    limits,
    input  logic                         status_clr,
    output float_mon_pkg::alarm_status_t status,
    output float_mon_pkg::event_cnt_t    event_count
);

    import float_mon_pkg::*;

    // ==============================
    // Window check to debounce
    // ==============================
    // One record per valid sample
    exceed_t exceed_w;

    limit_window limit_window_i (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .sample_data  (sample_data),
        .sample_valid (sample_valid),
        .limits       (limits),
        .exceed       (exceed_w)
    );

    // Alarms, sticky bits and event count
    alarm_debounce alarm_debounce_i (
        .clk_sys     (clk_sys),
        .rst_sys_n   (rst_sys_n),
        .exceed      (exceed_w),
        .status_clr  (status_clr),
        .status      (status),
        .event_count (event_count)
    );

endmodule

/* tests/float_monitor_tb.sv */
// Testbench for the single-precision limit monitor
// Drives sample streams into float_monitor_top and checks status and
// event_count every cycle against a reference model; compile with verilog.f
`timescale 1ns/10ps
`include "float_mon_macros.svh"

module float_monitor_tb;

    import float_mon_pkg::*;

    // ==============================
    // Lengths and constants
    // ==============================
    localparam int RST_CYCLES = 3;
    localparam int N_RAND     = 16;
    localparam int L          = `DEBOUNCE_LEN;
    // Cycles in each phase at one per step
    localparam int P1_CYCLES  = (N_RAND + 11) * L + 4;
    localparam int P2_CYCLES  = 7 * L + 9;
    localparam int P3_CYCLES  = 5 * L + 15;
    localparam int P4_CYCLES  = 2 * L + 21;
    localparam int P5_CYCLES  = 8 * L + 3;
    localparam int P6_CYCLES  = 2 * L + 11;
    localparam int STIM_CYCLES = RST_CYCLES + P1_CYCLES + P2_CYCLES + P3_CYCLES
                                 + P4_CYCLES + P5_CYCLES + P6_CYCLES + 4;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 20;

    // 10.0 and -10.0
    localparam float32_t LIM_HI = 32'h4120_0000;
    localparam float32_t LIM_LO = 32'hC120_0000;
    // 12.0, -12.0 and 1.0
    localparam float32_t HI_OUT = 32'h4140_0000;
    localparam float32_t LO_OUT = 32'hC140_0000;
    localparam float32_t MID    = 32'h3F80_0000;

    // Expected outputs after one edge
    typedef struct packed {
        alarm_status_t status;
        event_cnt_t    count;
    } expect_t;

    logic          clk_sys = 1'b0;
    logic          rst_sys_n;
    float32_t      sample_data;
    logic          sample_valid;
    limit_cfg_t    limits;
    logic          status_clr;
    alarm_status_t status;
    event_cnt_t    event_count;

    // Model state
    int         m_run [2];
    logic [1:0] m_alarm;
    logic [1:0] m_sticky;
    logic [1:0] m_rise;
    event_cnt_t m_count;
    // Record of the sample taken on the previous edge
    logic       rec_valid;
    logic [1:0] rec_hit;
    expect_t    m_exp;
    expect_t    chk_exp;
    expect_t    exp_q [$];
    int         cycle_cnt = 0;

    float_monitor_top dut_i (
        .clk_sys      (clk_sys),
        .rst_sys_n    (rst_sys_n),
        .sample_data  (sample_data),
        .sample_valid (sample_valid),
        .limits       (limits),
        .status_clr   (status_clr),
        .status       (status),
        .event_count  (event_count)
    );

    initial begin
        forever #50 clk_sys = ~clk_sys;
    end

    // ==============================
    // Reference model
    // ==============================
    // Unsigned key whose integer order is the float order
    // Negatives get inverted magnitude, so -0 lands just below +0
    function automatic logic [`FLOAT_W-1:0] order_key(input float32_t f);
        if (f[`FLOAT_W-1]) begin
            return {1'b0, ~f[`FLOAT_W-2:0]};
        end
        return {1'b1, f[`FLOAT_W-2:0]};
    endfunction

    function automatic logic ref_gt(input float32_t a, input float32_t b);
        return order_key(a) > order_key(b);
    endfunction

    always @(posedge clk_sys) begin
        if (!rst_sys_n) begin
            m_run[0]  = 0;
            m_run[1]  = 0;
            m_alarm   = 2'b00;
            m_sticky  = 2'b00;
            m_count   = '0;
            rec_valid = 1'b0;
            rec_hit   = 2'b00;
        end else begin
            // Debounce on last edge's record
            // Index 0 is the high side and 1 the low side
            m_rise = 2'b00;
            if (rec_valid) begin
                for (int d = 0; d < 2; d++) begin
                    if (!rec_hit[d]) begin
                        m_run[d]   = 0;
                        m_alarm[d] = 1'b0;
                    end else if (!m_alarm[d]) begin
                        m_run[d] = m_run[d] + 1;
                        if (m_run[d] == L) begin
                            m_alarm[d] = 1'b1;
                            m_rise[d]  = 1'b1;
                        end
                    end
                end
            end
            for (int d = 0; d < 2; d++) begin
                // Set beats clear
                if (m_rise[d]) begin
                    m_sticky[d] = 1'b1;
                end else if (status_clr) begin
                    m_sticky[d] = 1'b0;
                end
                if (m_rise[d] && (m_count != '1)) begin
                    m_count = m_count + event_cnt_t'(1);
                end
            end
            // Window check of the sample taken now
            rec_valid  = sample_valid;
            rec_hit[0] = sample_valid && ref_gt(sample_data, limits.high);
            rec_hit[1] = sample_valid && ref_gt(limits.low, sample_data);
        end
        m_exp.status.alarm_high  = m_alarm[0];
        m_exp.status.alarm_low   = m_alarm[1];
        m_exp.status.sticky_high = m_sticky[0];
        m_exp.status.sticky_low  = m_sticky[1];
        m_exp.count              = m_count;
        exp_q.push_back(m_exp);
    end

    // ==============================
    // Comparison and timeout
    // ==============================
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, actual,
                     expected, $time);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Outputs settled mid-cycle
    always @(negedge clk_sys) begin
        if (exp_q.size() == 0) begin
            $display("No expected value was queued for the check at %0t", $time);
            $display("** FAIL **");
            $fatal(1);
        end else begin
            chk_exp = exp_q.pop_front();
            // Asynchronous reset clears outputs before the model sees it
            if (!rst_sys_n) begin
                chk_exp = '0;
            end
            check_value("status", 32'(status), 32'(chk_exp.status));
            check_value("event_count", 32'(event_count), 32'(chk_exp.count));
        end
    end

    always @(posedge clk_sys) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: the test sequence ran past %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    // One clock per call
    task automatic step(input logic valid, input float32_t data, input logic clr);
        @(posedge clk_sys);
        #1;
        sample_valid = valid;
        sample_data  = data;
        status_clr   = clr;
    endtask

    // Random data on idle cycles must stay invisible
    task automatic idle_cycles(input int n);
        repeat (n) step(1'b0, float32_t'($urandom), 1'b0);
    endtask

    task automatic run_samples(input float32_t data, input int n);
        repeat (n) step(1'b1, data, 1'b0);
    endtask

    task automatic pulse_clear();
        step(1'b0, '0, 1'b1);
    endtask

    // Limits only change on an idle cycle
    task automatic set_limits(input float32_t hi, input float32_t lo);
        @(posedge clk_sys);
        #1;
        sample_valid = 1'b0;
        status_clr   = 1'b0;
        limits.high  = hi;
        limits.low   = lo;
    endtask

    task automatic reset_during_run();
        @(posedge clk_sys);
        #1;
        rst_sys_n    = 1'b0;
        sample_valid = 1'b1;
        sample_data  = HI_OUT;
        repeat (RST_CYCLES) @(posedge clk_sys);
        #1;
        rst_sys_n    = 1'b1;
        sample_valid = 1'b0;
    endtask

    // Both signs around the 10.0 limits
    function automatic float32_t rand_float();
        logic                    sign;
        logic [`FLOAT_EXP_W-1:0] exp_f;
        logic [`FLOAT_MAN_W-1:0] man;
        sign  = 1'($urandom_range(0, 1));
        exp_f = `FLOAT_EXP_W'(126 + $urandom_range(0, 8));
        man   = `FLOAT_MAN_W'($urandom);
        return {sign, exp_f, man};
    endfunction

    initial begin
        void'($urandom(1458));
        rst_sys_n    = 1'b0;
        sample_data  = '0;
        sample_valid = 1'b0;
        limits.high  = LIM_HI;
        limits.low   = LIM_LO;
        status_clr   = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_sys);
        #1;
        rst_sys_n = 1'b1;

        $display("Ordering rule");
        for (int i = 0; i < N_RAND; i++) begin
            run_samples(rand_float(), L);
        end
        // Equal to a limit and one ulp either side, then signed zeros
        run_samples(LIM_HI, L);
        run_samples(LIM_LO, L);
        run_samples(32'h4120_0001, L);
        run_samples(32'hC120_0001, L);
        run_samples(32'h411F_FFFF, L);
        run_samples(32'h0000_0000, L);
        run_samples(32'h8000_0000, L);
        // Both limits at -0 so that +0 lies above the window
        set_limits(32'h8000_0000, 32'h8000_0000);
        run_samples(32'h0000_0000, L);
        run_samples(32'h8000_0000, L);
        run_samples(MID, L);
        run_samples(32'hBF80_0000, L);
        set_limits(LIM_HI, LIM_LO);
        run_samples(MID, 1);
        idle_cycles(1);

        $display("Debounce");
        repeat (3) begin
            run_samples(HI_OUT, L - 1);
            run_samples(MID, 1);
        end
        repeat (3) begin
            run_samples(LO_OUT, L - 1);
            run_samples(MID, 1);
        end
        run_samples(HI_OUT, L);
        idle_cycles(3);
        run_samples(HI_OUT, 2);
        run_samples(MID, 1);
        idle_cycles(3);

        $display("Gaps in sample_valid");
        repeat (L) begin
            run_samples(HI_OUT, 1);
            idle_cycles(3);
        end
        run_samples(HI_OUT, 1);
        idle_cycles(2);
        run_samples(MID, 1);
        idle_cycles(2);
        run_samples(LO_OUT, L - 1);
        idle_cycles(3);
        run_samples(LO_OUT, 1);
        idle_cycles(3);
        run_samples(MID, 1);
        idle_cycles(2);

        $display("Sticky bits");
        pulse_clear();
        idle_cycles(2);
        run_samples(HI_OUT, L);
        idle_cycles(2);
        run_samples(MID, 1);
        idle_cycles(2);
        pulse_clear();
        idle_cycles(2);
        // Clear lands on the same edge as the alarm set
        run_samples(HI_OUT, L);
        pulse_clear();
        idle_cycles(3);
        run_samples(MID, 1);
        idle_cycles(2);
        pulse_clear();
        idle_cycles(2);

        $display("Alternating runs");
        repeat (4) begin
            run_samples(HI_OUT, L);
            run_samples(LO_OUT, L);
        end
        run_samples(MID, 1);
        idle_cycles(2);

        $display("Reset during activity");
        run_samples(HI_OUT, L);
        idle_cycles(1);
        reset_during_run();
        // Run starts over after reset
        run_samples(HI_OUT, L - 1);
        idle_cycles(3);
        run_samples(HI_OUT, 1);
        idle_cycles(3);

        idle_cycles(4);
        $display("** PASS **");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hdl
hdl/float_mon_pkg.sv
hdl/float_gt_cmp.sv
hdl/limit_window.sv
hdl/alarm_debounce.sv
hdl/float_monitor_top.sv
tests/float_monitor_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the limit monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module float_monitor_tb \
    -f verilog.f -o float_monitor_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/float_monitor_sim > sim.log 2>&1
cat sim.log
grep -q "\*\* FAIL \*\*" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "\*\* PASS \*\*" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
